// ==== flist.f ====
+incdir+verif
logic/isa_pkg.sv
logic/datapath_pkg.sv
logic/control_unit.sv
logic/reg_status_table.sv
logic/fu_credits.sv
logic/dispatch.sv
verif/dispatch_tb.sv

// ==== verif/dispatch_tests.svh ====
task automatic check_stall(input logic exp);
    assert (stall === exp) else report_mismatch("stall", stall, exp);
endtask

task automatic expect_issue_valid(input fu_vec_t exp);
    assert (issue_valid === exp) else report_mismatch("issue_valid", issue_valid, exp);
endtask

task automatic compare_s_payload(input s_issue_t exp);
    assert (s_issue === exp) else report_mismatch("s_issue", s_issue, exp);
endtask

task automatic compare_m_payload(input m_issue_t exp);
    assert (m_issue === exp) else report_mismatch("m_issue", m_issue, exp);
endtask

// stimulus tasks start and end just after a falling edge
task automatic present(input word_t w);
    instr       = w;
    instr_valid = 1'b1;
endtask

task automatic drop_instr();
    instr_valid = 1'b0;
    instr       = '0;
endtask

// instruction must be taken at the very next rising edge
task automatic send_now(input word_t w);
    present(w);
    @(posedge CLK);
    check_stall(1'b0);
    @(negedge CLK);
    drop_instr();
endtask

task automatic hold_stalled(input int n);
    repeat (n) begin
        @(posedge CLK);
        check_stall(1'b1);
        @(negedge CLK);
    end
endtask

// one cycle of credit return and writeback, with nothing presented
task automatic return_and_retire(input fu_vec_t give, input wb_t w);
    credit_ret = give;
    wb         = w;
    @(negedge CLK);
    credit_ret = '0;
    wb         = '0;
    // an issue lasts exactly one cycle
    expect_issue_valid('0);
endtask

task automatic decode_and_issue();
    expect_issue_valid('0);
    check_stall(1'b0);
    // alu_op is bit 30 (imm[10]) on top of funct3
    send_now(i_type(OP_ALUI, 5'd7, 5'd3, 12'h4a5, 3'b110));
    expect_issue_valid(unit_bit(FU_ALU));
    compare_s_payload(scalar_payload(5'd7, 5'd3, 5'd5, 2'd0, 2'd0, 12'h4a5, 4'he));
    return_and_retire(unit_bit(FU_ALU), scalar_wb(5'd7));
    send_now(32'h0000_00ff);
    expect_issue_valid('0);
endtask

task automatic raw_tags();
    send_now(i_type(OP_LOAD, 5'd5, 5'd2, 12'h010, 3'b010));
    expect_issue_valid(unit_bit(FU_LDST));
    compare_s_payload(scalar_payload(5'd5, 5'd2, 5'd16, 2'd0, 2'd0, 12'h010, 4'h2));
    return_and_retire(unit_bit(FU_LDST), '0);
    send_now(sb_type(OP_BRANCH, 5'd5, 5'd6, 3'b000));
    expect_issue_valid(unit_bit(FU_BRANCH));
    compare_s_payload(scalar_payload(5'd0, 5'd5, 5'd6, 2'd2, 2'd0, 12'h006, 4'h0));
    return_and_retire(unit_bit(FU_BRANCH), scalar_wb(5'd5));
    send_now(sb_type(OP_BRANCH, 5'd5, 5'd6, 3'b000));
    compare_s_payload(scalar_payload(5'd0, 5'd5, 5'd6, 2'd0, 2'd0, 12'h006, 4'h0));
    return_and_retire(unit_bit(FU_BRANCH), '0);
    // busy again, then cleared in the reader's own cycle
    send_now(i_type(OP_LOAD, 5'd5, 5'd2, 12'h010, 3'b010));
    return_and_retire(unit_bit(FU_LDST), '0);
    wb = scalar_wb(5'd5);
    send_now(sb_type(OP_BRANCH, 5'd5, 5'd6, 3'b000));
    wb = '0;
    expect_issue_valid(unit_bit(FU_BRANCH));
    compare_s_payload(scalar_payload(5'd0, 5'd5, 5'd6, 2'd0, 2'd0, 12'h006, 4'h0));
    return_and_retire(unit_bit(FU_BRANCH), '0);
endtask

task automatic waw_and_x0();
    send_now(i_type(OP_LOAD, 5'd5, 5'd2, 12'h010, 3'b010));
    return_and_retire(unit_bit(FU_LDST), '0);
    present(r_type(OP_ALU, 5'd5, 5'd1, 5'd2, 3'b000, 1'b1));
    hold_stalled(4);
    wb = scalar_wb(5'd5);
    @(posedge CLK);
    check_stall(1'b0);
    @(negedge CLK);
    wb = '0;
    drop_instr();
    expect_issue_valid(unit_bit(FU_ALU));
    compare_s_payload(scalar_payload(5'd5, 5'd1, 5'd2, 2'd0, 2'd0, 12'h402, 4'h8));
    return_and_retire(unit_bit(FU_ALU), scalar_wb(5'd5));
    repeat (2) begin
        send_now(i_type(OP_ALUI, 5'd0, 5'd1, 12'h001, 3'b000));
        expect_issue_valid(unit_bit(FU_ALU));
        return_and_retire(unit_bit(FU_ALU), '0);
    end
endtask

task automatic credit_flow();
    send_now(r_type(OP_ALU, 5'd8, 5'd1, 5'd2, 3'b000, 1'b0));
    expect_issue_valid(unit_bit(FU_ALU));
    present(r_type(OP_ALU, 5'd9, 5'd3, 5'd4, 3'b000, 1'b0));
    hold_stalled(3);
    // the returned credit is usable one cycle later
    credit_ret = unit_bit(FU_ALU);
    @(posedge CLK);
    check_stall(1'b1);
    @(negedge CLK);
    credit_ret = '0;
    @(posedge CLK);
    check_stall(1'b0);
    @(negedge CLK);
    drop_instr();
    expect_issue_valid(unit_bit(FU_ALU));
    compare_s_payload(scalar_payload(5'd9, 5'd3, 5'd4, 2'd0, 2'd0, 12'h004, 4'h0));
    // spend every credit except load/store
    send_now(sb_type(OP_BRANCH, 5'd1, 5'd2, 3'b000));
    send_now(m_type(OP_MSTORE, 4'd0, 4'd1, 4'd2, 4'd3));
    send_now(m_type(OP_GEMM, 4'd1, 4'd0, 4'd0, 4'd0));
    send_now(sb_type(OP_STORE, 5'd1, 5'd2, 3'b010));
    expect_issue_valid(unit_bit(FU_LDST));
    return_and_retire('1, scalar_wb(5'd8));
    return_and_retire('0, scalar_wb(5'd9));
    return_and_retire('0, matrix_wb(4'd1));
endtask

task automatic matrix_path();
    word_t    w;
    m_issue_t m;
    send_now(i_type(OP_LOAD, 5'd10, 5'd1, 12'h000, 3'b010));
    return_and_retire(unit_bit(FU_LDST), '0);
    // ms3 of 5 puts x10 in the scalar rs1 field
    w = m_type(OP_MLOAD, 4'd3, 4'd0, 4'd0, 4'd5);
    m = '0;
    m.rd  = 4'd3;
    m.ms3 = 4'd5;
    m.rs1 = 5'd10;
    m.st1 = 2'd2;
    m.imm = 11'h300;
    send_now(w);
    expect_issue_valid(unit_bit(FU_MLDST));
    compare_m_payload(m);
    return_and_retire(unit_bit(FU_MLDST), scalar_wb(5'd10));
    w = m_type(OP_GEMM, 4'd4, 4'd1, 4'd3, 4'd2);
    m = '0;
    m.rd  = 4'd4;
    m.ms1 = 4'd1;
    m.ms2 = 4'd3;
    m.ms3 = 4'd2;
    m.t2  = 2'd2;
    m.rs1 = 5'd4;
    m.rs2 = 5'd19;
    m.imm = 11'h413;
    send_now(w);
    expect_issue_valid(unit_bit(FU_GEMM));
    compare_m_payload(m);
    return_and_retire(unit_bit(FU_GEMM), '0);
    present(m_type(OP_GEMM, 4'd3, 4'd0, 4'd0, 4'd0));
    hold_stalled(3);
    wb = matrix_wb(4'd3);
    @(posedge CLK);
    check_stall(1'b0);
    @(negedge CLK);
    wb = '0;
    drop_instr();
    expect_issue_valid(unit_bit(FU_GEMM));
    return_and_retire(unit_bit(FU_GEMM), matrix_wb(4'd3));
    return_and_retire('0, matrix_wb(4'd4));
endtask

task automatic flush_drop();
    present(i_type(OP_ALUI, 5'd12, 5'd1, 12'h003, 3'b000));
    flush = 1'b1;
    @(posedge CLK);
    check_stall(1'b0);
    @(negedge CLK);
    flush = 1'b0;
    drop_instr();
    expect_issue_valid('0);
    // with one credit per unit this stalls if the flushed ALUI had spent it
    send_now(r_type(OP_ALU, 5'd13, 5'd12, 5'd1, 3'b000, 1'b0));
    expect_issue_valid(unit_bit(FU_ALU));
    compare_s_payload(scalar_payload(5'd13, 5'd12, 5'd1, 2'd0, 2'd0, 12'h001, 4'h0));
    return_and_retire(unit_bit(FU_ALU), scalar_wb(5'd13));
endtask

// ==== verif/dispatch_tb.sv ====
`timescale 1ns/1ps

module dispatch_tb
    import isa_pkg::*, datapath_pkg::*;
;

    localparam int MAX_CYCLES = 2000;

    logic     CLK;
    logic     nRST;
    logic     instr_valid;
    word_t    instr;
    logic     flush;
    wb_t      wb;
    fu_vec_t  credit_ret;
    logic     stall;
    fu_vec_t  issue_valid;
    s_issue_t s_issue;
    m_issue_t m_issue;

    int cycles = 0;
    int errors = 0;

    dispatch #(
        .FU_CREDITS (1)
    ) dut (
        .CLK         (CLK),
        .nRST        (nRST),
        .instr_valid (instr_valid),
        .instr       (instr),
        .flush       (flush),
        .wb          (wb),
        .credit_ret  (credit_ret),
        .stall       (stall),
        .issue_valid (issue_valid),
        .s_issue     (s_issue),
        .m_issue     (m_issue)
    );

    initial CLK = 1'b0;
    always #20 CLK = ~CLK;

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout: test sequence still running after %0d cycles", MAX_CYCLES);
            $display("Verification failed");
            $fatal(1, "run aborted");
        end
    end

    // instruction word builders, field positions as in the ISA
    function automatic word_t r_type(opcode_t op, regbits_t rd, regbits_t rs1, regbits_t rs2,
                                     logic [2:0] f3, logic alt);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, op};
    endfunction

    function automatic word_t i_type(opcode_t op, regbits_t rd, regbits_t rs1,
                                     logic [11:0] imm, logic [2:0] f3);
        return {imm, rs1, f3, rd, op};
    endfunction

    // store and branch, the rd field is left zero
    function automatic word_t sb_type(opcode_t op, regbits_t rs1, regbits_t rs2, logic [2:0] f3);
        return {7'b0, rs2, rs1, f3, 5'b0, op};
    endfunction

    function automatic word_t m_type(opcode_t op, matbits_t mrd, matbits_t ms1, matbits_t ms2,
                                     matbits_t ms3);
        return {mrd, ms1, ms2, ms3, 9'b0, op};
    endfunction

    function automatic s_issue_t scalar_payload(regbits_t rd, regbits_t rs1, regbits_t rs2,
                                                tag_t t1, tag_t t2, logic [11:0] imm,
                                                logic [3:0] alu_op);
        s_issue_t s;
        s.rd     = rd;
        s.rs1    = rs1;
        s.rs2    = rs2;
        s.t1     = t1;
        s.t2     = t2;
        s.imm    = imm;
        s.alu_op = alu_op;
        return s;
    endfunction

    function automatic wb_t scalar_wb(regbits_t r);
        wb_t w;
        w = '0;
        w.s_rw_en = 1'b1;
        w.s_rw    = r;
        return w;
    endfunction

    function automatic wb_t matrix_wb(matbits_t r);
        wb_t w;
        w = '0;
        w.m_rw_en = 1'b1;
        w.m_rw    = r;
        return w;
    endfunction

    function automatic fu_vec_t unit_bit(fu_idx_t f);
        fu_vec_t v;
        v = '0;
        v[f] = 1'b1;
        return v;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        errors++;
        $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
        $display("Verification failed");
        $fatal(1, "stopped at first error");
    endtask

    `include "dispatch_tests.svh"

    initial begin
        nRST        = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        flush       = 1'b0;
        wb          = '0;
        credit_ret  = '0;
        repeat (16) @(negedge CLK);
        nRST = 1'b1;
        @(negedge CLK);

        decode_and_issue();
        raw_tags();
        waw_and_x0();
        credit_flow();
        matrix_path();
        flush_drop();

        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== logic/dispatch.sv ====
`timescale 1ns/1ps

module dispatch
    import isa_pkg::*, datapath_pkg::*;
#(
    parameter int FU_CREDITS = 2
) (
    input  logic     CLK,
    input  logic     nRST,
    input  logic     instr_valid,
    input  word_t    instr,
    input  logic     flush,
    input  wb_t      wb,
    input  fu_vec_t  credit_ret,
    output logic     stall,
    output fu_vec_t  issue_valid,
    output s_issue_t s_issue,
    output m_issue_t m_issue
);

    decode_t dec;

    // register fields, scalar and matrix views of the same word
    regbits_t s_rd;
    regbits_t s_rs1;
    regbits_t s_rs2;
    matbits_t m_rd;
    matbits_t m_s1;
    matbits_t m_s2;
    matbits_t m_s3;

    // status table ports
    logic           s_di_write;
    tag_t           s_di_tag;
    logic           s_dest_busy;
    tag_t [1:0]     s_src_tag;
    logic           m_di_write;
    tag_t           m_di_tag;
    logic           m_dest_busy;
    tag_t [2:0]     m_src_tag;

    fu_vec_t  target;
    fu_vec_t  avail;
    fu_vec_t  take;
    logic     waw;
    logic     no_credit;
    logic     accept;
    logic     to_scalar;
    logic     to_matrix;
    s_issue_t n_s_issue;
    m_issue_t n_m_issue;

    control_unit u_cu (
        .instr (instr),
        .dec   (dec)
    );

    assign s_rd  = instr[RD_LSB +: $bits(regbits_t)];
    assign s_rs1 = instr[RS1_LSB +: $bits(regbits_t)];
    assign s_rs2 = instr[RS2_LSB +: $bits(regbits_t)];
    assign m_rd  = instr[MRD_LSB +: $bits(matbits_t)];
    assign m_s1  = instr[MS1_LSB +: $bits(matbits_t)];
    assign m_s2  = instr[MS2_LSB +: $bits(matbits_t)];
    assign m_s3  = instr[MS3_LSB +: $bits(matbits_t)];

    reg_status_table #(
        .NREGS (32),
        .SEL_W ($bits(regbits_t)),
        .NSRC  (2)
    ) u_rst_s (
        .CLK       (CLK),
        .nRST      (nRST),
        .di_write  (s_di_write),
        .di_sel    (s_rd),
        .di_tag    (s_di_tag),
        .wb_write  (wb.s_rw_en),
        .wb_sel    (wb.s_rw),
        .dest_sel  (s_rd),
        .src_sel   ({s_rs2, s_rs1}),
        .dest_busy (s_dest_busy),
        .src_tag   (s_src_tag)
    );

    reg_status_table #(
        .NREGS (16),
        .SEL_W ($bits(matbits_t)),
        .NSRC  (3)
    ) u_rst_m (
        .CLK       (CLK),
        .nRST      (nRST),
        .di_write  (m_di_write),
        .di_sel    (m_rd),
        .di_tag    (m_di_tag),
        .wb_write  (wb.m_rw_en),
        .wb_sel    (wb.m_rw),
        .dest_sel  (m_rd),
        .src_sel   ({m_s3, m_s2, m_s1}),
        .dest_busy (m_dest_busy),
        .src_tag   (m_src_tag)
    );

    fu_credits #(
        .FU_CREDITS (FU_CREDITS)
    ) u_credits (
        .CLK   (CLK),
        .nRST  (nRST),
        .take  (take),
        .give  (credit_ret),
        .avail (avail)
    );

    // illegal opcodes have no target, so they never wait on a credit
    assign target = dec.legal ? fu_vec_t'(1) << dec.fu : '0;

    assign waw       = (dec.s_reg_write && s_dest_busy) || (dec.m_reg_write && m_dest_busy);
    assign no_credit = |(target & ~avail);

    assign stall  = instr_valid && !flush && (waw || no_credit);
    assign accept = instr_valid && !flush && !waw && !no_credit;
    assign take   = accept ? target : '0;

    // destination becomes busy with the producer class of the unit
    assign s_di_write = accept && dec.s_reg_write;
    assign s_di_tag   = (dec.fu == FU_LDST) ? TAG_S_LDST : TAG_S_ALU;
    assign m_di_write = accept && dec.m_reg_write;
    assign m_di_tag   = (dec.fu == FU_MLDST) ? TAG_M_LDST : TAG_M_GEMM;

    assign to_scalar = take[FU_ALU] || take[FU_LDST] || take[FU_BRANCH];
    assign to_matrix = take[FU_MLDST] || take[FU_GEMM];

    always_comb begin
        n_s_issue.rd     = s_rd;
        n_s_issue.rs1    = s_rs1;
        n_s_issue.rs2    = s_rs2;
        n_s_issue.t1     = s_src_tag[0];
        n_s_issue.t2     = s_src_tag[1];
        n_s_issue.imm    = dec.imm;
        n_s_issue.alu_op = dec.alu_op;

        n_m_issue.rd  = m_rd;
        n_m_issue.ms1 = m_s1;
        n_m_issue.ms2 = m_s2;
        n_m_issue.ms3 = m_s3;
        n_m_issue.t1  = m_src_tag[0];
        n_m_issue.t2  = m_src_tag[1];
        n_m_issue.t3  = m_src_tag[2];
        // base and stride come from the scalar table
        n_m_issue.rs1 = s_rs1;
        n_m_issue.rs2 = s_rs2;
        n_m_issue.st1 = s_src_tag[0];
        n_m_issue.st2 = s_src_tag[1];
        n_m_issue.imm = dec.imm[10:0];
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            issue_valid <= '0;
        end else begin
            issue_valid <= take;
        end
    end

    // payloads drop to zero whenever nothing goes to their side
    always_ff @(posedge CLK) begin
        s_issue <= to_scalar ? n_s_issue : '0;
        m_issue <= to_matrix ? n_m_issue : '0;
    end

    a_issue_onehot: assert property (
        @(posedge CLK) disable iff (!nRST)
        $onehot0(issue_valid)
    );

endmodule

// ==== logic/fu_credits.sv ====
`timescale 1ns/1ps

module fu_credits
    import isa_pkg::*, datapath_pkg::*;
#(
    parameter int FU_CREDITS = 1
) (
    input  logic    CLK,
    input  logic    nRST,
    input  fu_vec_t take,
    input  fu_vec_t give,
    output fu_vec_t avail
);

    localparam int CNT_W = $clog2(FU_CREDITS + 1);

    logic [CNT_W-1:0] count [NUM_FU];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NUM_FU; i++) begin
                count[i] <= CNT_W'(FU_CREDITS);
            end
        end else begin
            // take and give in one cycle cancel out
            for (int i = 0; i < NUM_FU; i++) begin
                if (take[i] && !give[i]) begin
                    count[i] <= count[i] - 1'b1;
                end else if (give[i] && !take[i]) begin
                    count[i] <= count[i] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_FU; i++) begin
            avail[i] = (count[i] != '0);
        end
    end

    for (genvar i = 0; i < NUM_FU; i++) begin : g_check
        a_no_underflow: assert property (
            @(posedge CLK) disable iff (!nRST)
            take[i] |-> count[i] != '0
        );
        // a unit cannot hand back more slots than it was given
        a_no_overflow: assert property (
            @(posedge CLK) disable iff (!nRST)
            give[i] |-> count[i] != CNT_W'(FU_CREDITS)
        );
    end

endmodule

// ==== logic/reg_status_table.sv ====
`timescale 1ns/1ps

module reg_status_table
    import datapath_pkg::*;
#(
    parameter int NREGS = 32,
    parameter int SEL_W = 5,
    parameter int NSRC  = 2
) (
    input  logic                       CLK,
    input  logic                       nRST,
    input  logic                       di_write,
    input  logic [SEL_W-1:0]           di_sel,
    input  tag_t                       di_tag,
    input  logic                       wb_write,
    input  logic [SEL_W-1:0]           wb_sel,
    input  logic [SEL_W-1:0]           dest_sel,
    input  logic [NSRC-1:0][SEL_W-1:0] src_sel,
    output logic                       dest_busy,
    output tag_t [NSRC-1:0]            src_tag
);

    // one producer tag per register, nonzero means busy
    tag_t [NREGS-1:0] tags;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            tags <= '0;
        end else begin
            if (wb_write) begin
                tags[wb_sel] <= TAG_READY;
            end
            // dispatch overrides a writeback to the same entry
            if (di_write) begin
                tags[di_sel] <= di_tag;
            end
        end
    end

    // reads see a same-cycle writeback as already cleared
    always_comb begin
        for (int i = 0; i < NSRC; i++) begin
            if (wb_write && wb_sel == src_sel[i]) begin
                src_tag[i] = TAG_READY;
            end else begin
                src_tag[i] = tags[src_sel[i]];
            end
        end
    end

    assign dest_busy = (tags[dest_sel] != TAG_READY) && !(wb_write && wb_sel == dest_sel);

    a_di_tag_nonzero: assert property (
        @(posedge CLK) disable iff (!nRST)
        di_write |-> di_tag != TAG_READY
    );

    // the WAW stall in dispatch must keep busy entries from being overwritten
    a_di_not_busy: assert property (
        @(posedge CLK) disable iff (!nRST)
        di_write |-> (tags[di_sel] == TAG_READY) || (wb_write && wb_sel == di_sel)
    );

endmodule

// ==== logic/control_unit.sv ====
`timescale 1ns/1ps

module control_unit
    import isa_pkg::*, datapath_pkg::*;
(
    input  word_t   instr,
    output decode_t dec
);

    opcode_t  opcode;
    regbits_t rd;

    assign opcode = instr[OPCODE_LSB +: $bits(opcode_t)];
    assign rd     = instr[RD_LSB +: $bits(regbits_t)];

    always_comb begin
        dec = '0;

        // alt bit on top of funct3
        dec.alu_op = {instr[ALT_BIT], instr[FUNCT3_LSB +: 3]};
        dec.imm    = instr[IMM_LSB +: 12];
        dec.legal  = 1'b1;

        case (opcode)
            OP_ALU, OP_ALUI: begin
                dec.fu          = FU_ALU;
                dec.s_reg_write = 1'b1;
            end
            OP_LOAD: begin
                dec.fu          = FU_LDST;
                dec.s_reg_write = 1'b1;
            end
            OP_STORE: begin
                dec.fu = FU_LDST;
            end
            OP_BRANCH: begin
                dec.fu = FU_BRANCH;
            end
            OP_MLOAD: begin
                dec.fu          = FU_MLDST;
                dec.m_reg_write = 1'b1;
            end
            OP_MSTORE: begin
                dec.fu = FU_MLDST;
            end
            OP_GEMM: begin
                dec.fu          = FU_GEMM;
                dec.m_reg_write = 1'b1;
            end
            default: begin
                // unknown opcode, dispatch drops it
                dec.legal = 1'b0;
            end
        endcase

        // x0 is hardwired, no result to track
        if (rd == '0) begin
            dec.s_reg_write = 1'b0;
        end
    end

endmodule

// ==== logic/datapath_pkg.sv ====
package datapath_pkg;

    import isa_pkg::*;

    // producer tag, 0 means the register value is ready
    typedef logic [1:0] tag_t;

    localparam tag_t TAG_READY = 2'd0;

    // scalar producers
    localparam tag_t TAG_S_ALU  = 2'd1;
    localparam tag_t TAG_S_LDST = 2'd2;

    // matrix producers
    localparam tag_t TAG_M_GEMM = 2'd1;
    localparam tag_t TAG_M_LDST = 2'd2;

    // one bit per functional unit, indexed by fu_idx_t
    typedef logic [NUM_FU-1:0] fu_vec_t;

    // decoder output
    typedef struct packed {
        logic        legal;
        fu_idx_t     fu;
        logic        s_reg_write;
        logic        m_reg_write;
        logic [3:0]  alu_op;
        logic [11:0] imm;
    } decode_t;

    // writeback commit, clears table entries
    typedef struct packed {
        logic     s_rw_en;
        regbits_t s_rw;
        logic     m_rw_en;
        matbits_t m_rw;
    } wb_t;

    // payload to ALU, load/store and branch
    typedef struct packed {
        regbits_t    rd;
        regbits_t    rs1;
        regbits_t    rs2;
        tag_t        t1;
        tag_t        t2;
        logic [11:0] imm;
        logic [3:0]  alu_op;
    } s_issue_t;

    // payload to matrix load/store and GEMM
    typedef struct packed {
        matbits_t    rd;
        matbits_t    ms1;
        matbits_t    ms2;
        matbits_t    ms3;
        tag_t        t1;
        tag_t        t2;
        tag_t        t3;
        // scalar base and stride for matrix memory ops
        regbits_t    rs1;
        regbits_t    rs2;
        tag_t        st1;
        tag_t        st2;
        logic [10:0] imm;
    } m_issue_t;

endpackage

// ==== logic/isa_pkg.sv ====
package isa_pkg;

    // raw instruction and register numbers
    typedef logic [31:0] word_t;
    typedef logic [4:0]  regbits_t;
    typedef logic [3:0]  matbits_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  fu_idx_t;

    // major opcodes, bits 6:0
    localparam opcode_t OP_ALU    = 7'b0110011;
    localparam opcode_t OP_ALUI   = 7'b0010011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_MLOAD  = 7'b0001011;
    localparam opcode_t OP_MSTORE = 7'b0101011;
    localparam opcode_t OP_GEMM   = 7'b1011011;

    // scalar field positions (lsb of each field)
    localparam int OPCODE_LSB = 0;
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int IMM_LSB    = 20;
    localparam int ALT_BIT    = 30;

    // matrix field positions, these overlap the scalar ones
    localparam int MRD_LSB = 28;
    localparam int MS1_LSB = 24;
    localparam int MS2_LSB = 20;
    localparam int MS3_LSB = 16;

    // functional units
    localparam int NUM_FU = 5;

    localparam fu_idx_t FU_ALU    = 3'd0;
    localparam fu_idx_t FU_LDST   = 3'd1;
    localparam fu_idx_t FU_BRANCH = 3'd2;
    localparam fu_idx_t FU_MLDST  = 3'd3;
    localparam fu_idx_t FU_GEMM   = 3'd4;

endpackage
